// ==== anim_core/anim_select.sv ====
`default_nettype none

`include "anim_macros.svh"

module anim_select (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    next_anim,      // Press pulse, anim up
    input  wire                    prev_anim,      // Press pulse, anim down
    input  wire                    frame_tick,     // Advance one frame
    output anim_pkg::anim_status_t status          // Registered anim and frame
);
    import anim_pkg::*;

    localparam anim_idx_t ANIM_LAST = anim_idx_t'(`ANIM_COUNT - 1);

    anim_idx_t  anim_q;
    frame_idx_t frame_q;
    frame_idx_t frame_last;                        // Wrap point of the current anim

    assign frame_last = FRAME_LIMIT[anim_q];

    // Anim change beats a tick, next beats prev
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            anim_q  <= '0;
            frame_q <= '0;
        end else if (next_anim) begin
            anim_q  <= (anim_q == ANIM_LAST) ? anim_idx_t'(0) : anim_q + 1'b1;
            frame_q <= '0;                         // New anim starts at its first frame
        end else if (prev_anim) begin
            anim_q  <= (anim_q == anim_idx_t'(0)) ? ANIM_LAST : anim_q - 1'b1;
            frame_q <= '0;
        end else if (frame_tick) begin
            frame_q <= (frame_q == frame_last) ? frame_idx_t'(0) : frame_q + 1'b1;
        end
    end

    assign status.anim  = anim_q;
    assign status.frame = frame_q;

    a_frame_in_range : assert property (
        @(posedge clk) disable iff (reset) frame_q <= FRAME_LIMIT[anim_q]
    );

endmodule

`default_nettype wire

// ==== anim_core/frame_timer.sv ====
`default_nettype none

`include "anim_macros.svh"

module frame_timer #(
    parameter int period_step = `ANIM_PERIOD_STEP      // Cycles per speed level
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  faster,                               // Press pulse, level down
    input  wire  slower,                               // Press pulse, level up
    output logic frame_tick                            // One cycle per frame period
);
    import anim_pkg::*;

    localparam int CNT_W = $clog2(`ANIM_SPEED_MAX * period_step + 1);
    localparam speed_t SPEED_MIN   = speed_t'(`ANIM_SPEED_MIN);
    localparam speed_t SPEED_MAX   = speed_t'(`ANIM_SPEED_MAX);
    localparam speed_t SPEED_RESET = speed_t'(`ANIM_SPEED_RESET);

    speed_t           speed_q;
    speed_t           speed_d;
    logic             speed_change;
    logic [CNT_W-1:0] cycle_cnt;
    logic [CNT_W-1:0] period_last;                     // Last count of the current period

    // faster wins when both pulse together
    always_comb begin
        speed_d = speed_q;
        if (faster) begin
            if (speed_q > SPEED_MIN) speed_d = speed_q - 1'b1;
        end else if (slower) begin
            if (speed_q < SPEED_MAX) speed_d = speed_q + 1'b1;
        end
    end

    assign speed_change = (speed_d != speed_q);        // Press at a bound is ignored
    assign period_last  = CNT_W'(int'(speed_q) * period_step - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            speed_q    <= SPEED_RESET;
            cycle_cnt  <= '0;
            frame_tick <= 1'b0;
        end else begin
            speed_q <= speed_d;
            if (speed_change) begin
                cycle_cnt  <= '0;                      // New period starts now
                frame_tick <= 1'b0;
            end else if (cycle_cnt == period_last) begin
                cycle_cnt  <= '0;
                frame_tick <= 1'b1;
            end else begin
                cycle_cnt  <= cycle_cnt + 1'b1;
                frame_tick <= 1'b0;
            end
        end
    end

    a_speed_bounds : assert property (
        @(posedge clk) disable iff (reset) (speed_q >= SPEED_MIN) && (speed_q <= SPEED_MAX)
    );

endmodule

`default_nettype wire

// ==== buttons/button_debounce.sv ====
`default_nettype none

`include "anim_macros.svh"

module button_debounce #(
    parameter int debounce_cycles = `ANIM_DEBOUNCE_CYCLES   // High samples needed per press
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire anim_pkg::anim_buttons_t btn_raw,  // Asynchronous button levels
    output anim_pkg::anim_buttons_t      cmd       // One pulse per accepted press
);
    import anim_pkg::*;

    localparam int NUM_BTN = $bits(anim_buttons_t);
    localparam int CNT_W   = $clog2(debounce_cycles + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(debounce_cycles - 1);

    logic [NUM_BTN-1:0] raw_bits;
    logic [NUM_BTN-1:0] sync_q1;                   // First synchroniser stage
    logic [NUM_BTN-1:0] sync_q2;                   // Second stage, safe to use
    logic [NUM_BTN-1:0] pulse;

    assign raw_bits = btn_raw;
    assign cmd      = anim_buttons_t'(pulse);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= raw_bits;
            sync_q2 <= sync_q1;
        end
    end

    // Same filter for every button
    for (genvar i = 0; i < NUM_BTN; i++) begin : g_btn
        logic [CNT_W-1:0] stable_cnt;              // Consecutive high samples, saturating
        logic             armed;                   // Cleared after the pulse until release
        logic             fire_q;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                stable_cnt <= '0;
                armed      <= 1'b1;
                fire_q     <= 1'b0;
            end else if (!sync_q2[i]) begin
                stable_cnt <= '0;                  // Any low sample restarts the count
                armed      <= 1'b1;                // Release rearms the button
                fire_q     <= 1'b0;
            end else begin
                fire_q <= armed && (stable_cnt == CNT_LAST);
                if (stable_cnt == CNT_LAST) begin
                    armed <= 1'b0;                 // Held button stays silent
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end

        assign pulse[i] = fire_q;

        // A press never yields a pulse longer than one cycle
        a_single_pulse : assert property (
            @(posedge clk) disable iff (reset) fire_q |=> !fire_q
        );
    end

endmodule

`default_nettype wire

// ==== common/anim_macros.svh ====
`ifndef ANIM_MACROS_SVH
`define ANIM_MACROS_SVH

// Build-time defaults for the seven-segment animation player
// Values assume a 10 MHz board clock

// Stable cycles a button must be seen high, about 2 ms at 10 MHz
`define ANIM_DEBOUNCE_CYCLES 20000

// Cycles per speed level, 100 ms at 10 MHz
`define ANIM_PERIOD_STEP 1_000_000

// Speed level bounds, level times step gives the frame period
`define ANIM_SPEED_MIN 1
`define ANIM_SPEED_MAX 19

// Level loaded on reset, one frame per second
`define ANIM_SPEED_RESET 10

// Number of selectable animations
`define ANIM_COUNT 8

`endif

// ==== common/anim_pkg.sv ====
`default_nettype none

`include "anim_macros.svh"

package anim_pkg;

    // One bit per push button, used for raw levels and for press pulses
    typedef struct packed {
        logic next_anim;                     // Step to the next animation
        logic prev_anim;                     // Step to the previous animation
        logic faster;                        // Shorter frame period
        logic slower;                        // Longer frame period
    } anim_buttons_t;

    typedef logic [2:0] anim_idx_t;          // Animation number
    typedef logic [4:0] frame_idx_t;         // Frame within an animation
    typedef logic [4:0] speed_t;             // Speed level, 1 is fastest

    // Current position of the player
    typedef struct packed {
        anim_idx_t  anim;
        frame_idx_t frame;
    } anim_status_t;

    // Segment drive, bit 0 is a, bit 6 is g, bit 7 is dp
    typedef logic [7:0] seg_t;

    localparam seg_t SEG_A  = 8'h01;
    localparam seg_t SEG_B  = 8'h02;
    localparam seg_t SEG_C  = 8'h04;
    localparam seg_t SEG_D  = 8'h08;
    localparam seg_t SEG_E  = 8'h10;
    localparam seg_t SEG_F  = 8'h20;
    localparam seg_t SEG_G  = 8'h40;
    localparam seg_t SEG_DP = 8'h80;

    // Last frame index per animation, frame wraps to 0 after it
    localparam frame_idx_t FRAME_LIMIT [`ANIM_COUNT] = '{
        5'd9,                                // Count up
        5'd9,                                // Count down
        5'd5,                                // Spin
        5'd5,                                // Spin reversed
        5'd7,                                // Growing ring
        5'd3,                                // Bars
        5'd11,                               // Snake
        5'd15                                // Blink
    };

endpackage

`default_nettype wire

// ==== display/seg7_pattern.sv ====
`default_nettype none

module seg7_pattern (
    input  wire                    clk,
    input  wire                    reset,
    input  wire anim_pkg::anim_status_t status,    // Anim and frame to show
    output anim_pkg::seg_t         segments        // Registered segment drive
);
    import anim_pkg::*;

    seg_t pattern_d;

    // Decimal digit table, dp always off
    function automatic seg_t digit_seg(input logic [3:0] digit);
        case (digit)
            4'd0:    digit_seg = 8'h3F;
            4'd1:    digit_seg = 8'h06;
            4'd2:    digit_seg = 8'h5B;
            4'd3:    digit_seg = 8'h4F;
            4'd4:    digit_seg = 8'h66;
            4'd5:    digit_seg = 8'h6D;
            4'd6:    digit_seg = 8'h7D;
            4'd7:    digit_seg = 8'h07;
            4'd8:    digit_seg = 8'h7F;
            4'd9:    digit_seg = 8'h6F;
            default: digit_seg = SEG_G;            // Out of range shows a dash
        endcase
    endfunction

    always_comb begin
        case (status.anim)
            3'd0: pattern_d = digit_seg(status.frame[3:0]);
            3'd1: pattern_d = digit_seg(4'd9 - status.frame[3:0]);
            3'd2: begin                            // Clockwise spin
                case (status.frame)
                    5'd0:    pattern_d = SEG_A;
                    5'd1:    pattern_d = SEG_B;
                    5'd2:    pattern_d = SEG_C;
                    5'd3:    pattern_d = SEG_D;
                    5'd4:    pattern_d = SEG_E;
                    default: pattern_d = SEG_F;
                endcase
            end
            3'd3: begin                            // Counter-clockwise spin
                case (status.frame)
                    5'd0:    pattern_d = SEG_A;
                    5'd1:    pattern_d = SEG_F;
                    5'd2:    pattern_d = SEG_E;
                    5'd3:    pattern_d = SEG_D;
                    5'd4:    pattern_d = SEG_C;
                    default: pattern_d = SEG_B;
                endcase
            end
            3'd4: begin                            // Ring fills up, then holds
                case (status.frame)
                    5'd0:    pattern_d = SEG_A;
                    5'd1:    pattern_d = SEG_A | SEG_B;
                    5'd2:    pattern_d = SEG_A | SEG_B | SEG_C;
                    5'd3:    pattern_d = SEG_A | SEG_B | SEG_C | SEG_D;
                    5'd4:    pattern_d = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E;
                    default: pattern_d = SEG_A | SEG_B | SEG_C | SEG_D | SEG_E | SEG_F;
                endcase
            end
            3'd5: begin                            // Bar bounces top to bottom
                case (status.frame)
                    5'd0:    pattern_d = SEG_A;
                    5'd2:    pattern_d = SEG_D;
                    default: pattern_d = SEG_G;
                endcase
            end
            3'd6: begin                            // Two-segment snake, figure eight
                case (status.frame)
                    5'd0:    pattern_d = SEG_A | SEG_B;
                    5'd1:    pattern_d = SEG_B | SEG_C;
                    5'd2:    pattern_d = SEG_C | SEG_D;
                    5'd3:    pattern_d = SEG_D | SEG_E;
                    5'd4:    pattern_d = SEG_E | SEG_F;
                    5'd5:    pattern_d = SEG_F | SEG_A;
                    5'd6:    pattern_d = SEG_A | SEG_B;
                    5'd7:    pattern_d = SEG_B | SEG_G;
                    5'd8:    pattern_d = SEG_G | SEG_E;
                    5'd9:    pattern_d = SEG_E | SEG_D;
                    5'd10:   pattern_d = SEG_D | SEG_C;
                    default: pattern_d = SEG_C | SEG_G;
                endcase
            end
            default: pattern_d = status.frame[0] ? SEG_DP : SEG_G;  // Blink dp and g
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            segments <= digit_seg(4'd0);           // Anim 0, frame 0
        end else begin
            segments <= pattern_d;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/anim_pkg.sv
buttons/button_debounce.sv
anim_core/frame_timer.sv
anim_core/anim_select.sv
display/seg7_pattern.sv
verilog/seven_seg_anim_top.sv
sim/tb_clock_gen.sv
sim/seven_seg_anim_tb.sv

// ==== sim/seven_seg_anim_tb.sv ====
`default_nettype none

`include "anim_macros.svh"

module seven_seg_anim_tb;
    import anim_pkg::*;

    localparam int DEB         = 4;                // Debounce length given to the DUT
    localparam int STEP        = 8;                // Cycles per speed level
    localparam int DRIVE_DELAY = 2;                // Input skew after the rising edge
    localparam int NUM_RANDOM  = 40;
    localparam int NUM_PRESSES = 5 + 11 + 20 + 18 + `ANIM_COUNT + NUM_RANDOM;
    // Longest hold, gap and settle of one press
    localparam int PRESS_MAX   = 60 + 18 + DEB + 6 + `ANIM_SPEED_MAX * STEP + 4;
    localparam int IDLE_MAX    = (11 * `ANIM_SPEED_RESET + `ANIM_COUNT * 17
                                  + 4 * `ANIM_SPEED_MAX) * STEP;
    localparam int CYCLE_LIMIT = NUM_PRESSES * PRESS_MAX + IDLE_MAX + 1000;

    wire                clk;
    wire                reset;
    anim_buttons_t      btn;
    wire seg_t          segments;
    wire anim_status_t  status;

    seg_t digit_table [10] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66,
                               8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F};  // Segments a..g per digit

    logic [15:0]  lfsr       = 16'd11728;          // Fixed seed
    int           cyc;                             // Rising edges since reset release
    int           errors     = 0;
    int           checks     = 0;
    string        test_name  = "reset_idle";
    anim_idx_t    exp_anim   = '0;
    frame_idx_t   exp_frame  = '0;
    int           exp_speed  = `ANIM_SPEED_RESET;
    int           tick_due   = `ANIM_SPEED_RESET * STEP + 1;  // Cycle of the next frame advance
    anim_status_t prev_st    = '0;                 // Status the segments should show now
    logic         pend_anim  = 1'b0;               // Anim press waiting for its pulse
    logic         pend_speed = 1'b0;               // Speed press waiting for its first frame
    logic         pend_up;
    int           pend_c0;                         // Cycle of the raw rise
    int           pend_level;                      // Speed level the press leads to
    int           kind;
    int           hold;

    tb_clock_gen #(.period(40), .reset_cycles(5)) clock0 (.clk(clk), .reset(reset));

    seven_seg_anim_top #(
        .debounce_cycles(DEB),
        .period_step    (STEP)
    ) dut0 (
        .clk     (clk),
        .reset   (reset),
        .btn     (btn),
        .segments(segments),
        .status  (status)
    );

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsr[0];
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic frame_idx_t frame_after(input anim_idx_t a, input frame_idx_t f);
        return (f == FRAME_LIMIT[a]) ? frame_idx_t'(0) : frame_idx_t'(f + 1);
    endfunction

    // Model step and checks, run where outputs are stable
    task automatic check_cycle();
        anim_status_t st;
        logic         advanced;
        int           pulse_cyc;
        seg_t         exp_seg;
        st       = status;
        advanced = (st.anim == exp_anim) && (st.frame == frame_after(exp_anim, exp_frame));
        if (st.anim != exp_anim) begin
            checks++;
            assert (pend_anim && cyc >= pend_c0 + DEB + 3 && cyc <= pend_c0 + DEB + 5) else begin
                errors++;
                $display("%s: animation changed at cycle %0d with no press due", test_name, cyc);
            end
            exp_anim  = pend_up ? anim_idx_t'((exp_anim + 1) % `ANIM_COUNT)
                                : anim_idx_t'((exp_anim + `ANIM_COUNT - 1) % `ANIM_COUNT);
            exp_frame = '0;
            pend_anim = 1'b0;
            if (cyc == tick_due) tick_due += exp_speed * STEP;  // Tick lost to the anim change
        end else if (pend_speed && cyc <= pend_c0 + DEB + 5) begin
            if (cyc == tick_due) begin                 // Old period runs until the pulse
                checks++;
                assert (advanced || cyc >= pend_c0 + DEB + 4) else begin
                    errors++;
                    $display("%s: frame tick missing at cycle %0d", test_name, cyc);
                end
                if (advanced) exp_frame = frame_after(exp_anim, exp_frame);
                tick_due += exp_speed * STEP;
            end
        end else if (pend_speed) begin
            if (advanced || cyc > pend_c0 + DEB + 6 + pend_level * STEP) begin
                pulse_cyc = cyc - pend_level * STEP - 2;   // Period restarts after the pulse
                checks++;
                assert (advanced && pulse_cyc >= pend_c0 + DEB + 2) else begin
                    errors++;
                    $display("%s: first frame at speed %0d at cycle %0d, outside press window",
                             test_name, pend_level, cyc);
                end
                if (advanced) exp_frame = frame_after(exp_anim, exp_frame);
                exp_speed  = pend_level;
                tick_due   = cyc + pend_level * STEP;
                pend_speed = 1'b0;
            end
        end else if (cyc == tick_due) begin
            exp_frame = frame_after(exp_anim, exp_frame);
            tick_due += exp_speed * STEP;
        end
        if (pend_anim) begin
            assert (cyc <= pend_c0 + DEB + 5) else begin
                errors++;
                $display("%s: anim press from cycle %0d never took effect", test_name, pend_c0);
                pend_anim = 1'b0;
            end
        end
        checks++;
        assert (st == {exp_anim, exp_frame}) else begin
            errors++;
            $display("Mismatch %s: expected anim %0d frame %0d, actual anim %0d frame %0d",
                     test_name, exp_anim, exp_frame, st.anim, st.frame);
            exp_anim  = st.anim;
            exp_frame = st.frame;
        end
        if (prev_st.anim <= 3'd1) begin                // Digit animations, up and down
            exp_seg = digit_table[(prev_st.anim == 3'd0) ? prev_st.frame : 9 - prev_st.frame];
            checks++;
            assert (segments == exp_seg) else begin
                errors++;
                $display("Mismatch %s: expected segments %h, actual %h", test_name, exp_seg,
                         segments);
            end
        end
        checks++;
        assert (segments != '0) else begin
            errors++;
            $display("%s: display went dark at cycle %0d", test_name, cyc);
        end
        if (prev_st.anim != 3'd7) begin
            checks++;
            assert (!segments[7]) else begin
                errors++;
                $display("%s: decimal point lit in anim %0d", test_name, prev_st.anim);
            end
        end
        prev_st = st;
    endtask

    // Button 0 next, 1 prev, 2 faster, 3 slower
    task automatic press(input int which, input int len, input int gap);
        @(posedge clk);
        #DRIVE_DELAY;
        btn = anim_buttons_t'(4'b1000 >> which);
        if (len >= DEB && which < 2) begin
            pend_up   = (which == 0);
            pend_c0   = cyc;
            pend_anim = 1'b1;
        end else if (len >= DEB) begin
            pend_level = (which == 2) ? exp_speed - 1 : exp_speed + 1;  // Lower level is faster
            if (pend_level >= `ANIM_SPEED_MIN && pend_level <= `ANIM_SPEED_MAX) begin
                pend_c0    = cyc;
                pend_speed = 1'b1;
            end
        end
        repeat (len) @(posedge clk);
        #DRIVE_DELAY;
        btn = '0;
        while (pend_anim || pend_speed) @(posedge clk);
        repeat (gap) @(posedge clk);
    endtask

    always @(posedge clk or posedge reset) begin
        if (reset) cyc <= 0;
        else       cyc <= cyc + 1;
    end

    always @(negedge clk) begin
        if (!reset) check_cycle();
    end

    always @(posedge clk) begin
        if (cyc >= CYCLE_LIMIT) begin
            $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("Run ended: %0d checks, %0d errors", checks, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        btn = '0;
        @(negedge reset);
        repeat (11 * `ANIM_SPEED_RESET * STEP) @(posedge clk);  // Idle through a full wrap
        test_name = "anim_step";
        press(0, 8, 6);
        press(1, 10, 6);
        press(1, 12, 6);                               // 0 wraps to 7
        test_name = "short_hold";
        press(0, 2, 6);
        test_name = "long_hold";
        press(0, 60, 6);
        test_name = "speed_bounds";
        repeat (11) press(2, 8, 4);                    // Down to 1, then against the floor
        repeat (20) press(3, 8, 4);                    // Up to 19, then against the ceiling
        repeat (18) press(2, 8, 4);
        test_name = "frame_wrap";
        repeat (`ANIM_COUNT) begin
            press(0, 8, 4);
            repeat ((FRAME_LIMIT[exp_anim] + 2) * exp_speed * STEP) @(posedge clk);
        end
        test_name = "random_mix";
        repeat (NUM_RANDOM) begin
            kind = rand_bits(2);
            if (rand_bits(3) == 0) hold = 1 + rand_bits(2) % 3;   // Too short for a press
            else                   hold = 6 + rand_bits(4) % 15;
            press(kind, hold, 3 + rand_bits(4));
        end
        test_name = "final_idle";
        repeat (4 * exp_speed * STEP) @(posedge clk);
        $display("Run ended: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int period       = 40,               // Clock period in time units
    parameter int reset_cycles = 5                 // Rising edges spent in reset
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;                           // Release just after an edge
    end

endmodule

`default_nettype wire

// ==== verilog/seven_seg_anim_top.sv ====
`default_nettype none

`include "anim_macros.svh"

module seven_seg_anim_top #(
    parameter int debounce_cycles = `ANIM_DEBOUNCE_CYCLES,  // Press filter length
    parameter int period_step     = `ANIM_PERIOD_STEP       // Cycles per speed level
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire anim_pkg::anim_buttons_t btn,          // Raw push buttons
    output wire anim_pkg::seg_t          segments,     // Display drive
    output wire anim_pkg::anim_status_t  status        // Current anim and frame
);
    import anim_pkg::*;

    anim_buttons_t cmd;                                // Debounced press pulses
    logic          frame_tick;

    button_debounce #(
        .debounce_cycles(debounce_cycles)
    ) u_debounce (
        .clk    (clk),
        .reset  (reset),
        .btn_raw(btn),
        .cmd    (cmd)
    );

    frame_timer #(
        .period_step(period_step)
    ) u_timer (
        .clk       (clk),
        .reset     (reset),
        .faster    (cmd.faster),
        .slower    (cmd.slower),
        .frame_tick(frame_tick)
    );

    anim_select u_select (
        .clk       (clk),
        .reset     (reset),
        .next_anim (cmd.next_anim),
        .prev_anim (cmd.prev_anim),
        .frame_tick(frame_tick),
        .status    (status)
    );

    seg7_pattern u_pattern (
        .clk     (clk),
        .reset   (reset),
        .status  (status),                             // Display follows status a cycle later
        .segments(segments)
    );

endmodule

`default_nettype wire
